/* logic/mpmc_bus_pkg.sv */
// =========================================================================
// Wishbone side of the memory controller
// =========================================================================

package mpmc_bus_pkg;

	// Word address and data widths of the slave port
	localparam int WB_ADR_W = 8;
	localparam int WB_DAT_W = 32;

	// Opcodes carried on the cmd input next to the usual Wishbone signals
	typedef enum logic [3:0] {
		CMD_LOAD  = 4'd0,
		CMD_STORE = 4'd1,
		CMD_ADD   = 4'd2,
		CMD_OR    = 4'd3,
		CMD_AND   = 4'd4,
		CMD_EOR   = 4'd5,
		CMD_MIN   = 4'd6,
		CMD_MAX   = 4'd7,
		CMD_MINU  = 4'd8,
		CMD_MAXU  = 4'd9,
		CMD_SWAP  = 4'd10
	} mpmc_cmd_t;

	// The request as it sits in the command register.
	// Only one cycle can be outstanding on a classic bus, so this single
	// register is the whole command queue
	typedef struct packed {
		logic                valid;
		mpmc_cmd_t           cmd;
		logic [WB_ADR_W-1:0] adr;
		// Store data, the operand of an atomic op, and later its result
		logic [WB_DAT_W-1:0] dat;
	} mpmc_req_t;

endpackage

/* logic/mpmc_ctrl_pkg.sv */
// =========================================================================
// Controller side: sequencing states, strip layout and memory timing
// =========================================================================

package mpmc_ctrl_pkg;
	import mpmc_bus_pkg::*;

	typedef enum logic [3:0] {
		IDLE, PRESET1, PRESET2,
		WRITE_DATA0, WRITE_DATA1, WRITE_DATA2, WRITE_DATA3,
		READ_DATA0, READ_DATA1, READ_DATA2,
		ALU, ALU1, WRITE_TRAMP1, ACK
	} mpmc_state_t;

	// A word is two strips, numbered 0 and STRIP_LAST
	localparam int STRIP_W     = 16;
	localparam int STRIP_LAST  = 1;
	localparam int STRIP_CNT_W = 2;
	localparam int STRIP_SEL_W = 1;
	// Strip address is the word address with the strip number below it
	localparam int STRIP_ADR_W = WB_ADR_W + STRIP_SEL_W;
	localparam int MEM_DEPTH   = 2 ** STRIP_ADR_W;

	// Memory timing
	localparam int READ_LATENCY   = 3;
	localparam int REFRESH_PERIOD = 8;
	localparam int REFRESH_CNT_W  = $clog2(REFRESH_PERIOD);
	localparam int CALIB_CYCLES   = 32;
	localparam int CALIB_CNT_W    = $clog2(CALIB_CYCLES);
	// Strips cleared per calibration cycle so the whole array is zero at the end
	localparam int CLEAR_STRIDE   = MEM_DEPTH / CALIB_CYCLES;

	localparam int TIMEOUT_LIMIT = 255;
	localparam int TIMEOUT_CNT_W = $clog2(TIMEOUT_LIMIT + 1);

	// Command to the strip memory.
	// With en low and we high it is the write-data strobe of WRITE_DATA3
	typedef struct packed {
		logic                   en;
		logic                   we;
		logic [STRIP_ADR_W-1:0] adr;
		logic [WB_DAT_W-1:0]    wdata;
	} strip_cmd_t;

	typedef struct packed {
		logic               rd_data_valid;
		logic [STRIP_W-1:0] data;
	} strip_rsp_t;

endpackage

/* logic/mpmc_rmw_alu.sv */
module mpmc_rmw_alu import mpmc_bus_pkg::*, mpmc_ctrl_pkg::*; (
	input  logic                clk,
	input  mpmc_state_t         state,
	input  mpmc_cmd_t           cmd,
	// Word read back from memory
	input  logic [WB_DAT_W-1:0] old_word,
	// Data sent by the master with the atomic op
	input  logic [WB_DAT_W-1:0] operand,
	output logic [WB_DAT_W-1:0] result
);

	logic [WB_DAT_W-1:0] alu_out;
	logic                lt_signed;
	logic                lt_unsigned;

	// Comparisons shared by the min and max variants
	assign lt_signed   = $signed(old_word) < $signed(operand);
	assign lt_unsigned = old_word < operand;

	always_comb begin
		case (cmd)
		// Wraps around, the carry is dropped
		CMD_ADD:
			alu_out = old_word + operand;
		CMD_OR:
			alu_out = old_word | operand;
		CMD_AND:
			alu_out = old_word & operand;
		CMD_EOR:
			alu_out = old_word ^ operand;
		CMD_MIN:
			alu_out = lt_signed ? old_word : operand;
		CMD_MAX:
			alu_out = lt_signed ? operand : old_word;
		CMD_MINU:
			alu_out = lt_unsigned ? old_word : operand;
		CMD_MAXU:
			alu_out = lt_unsigned ? operand : old_word;
		CMD_SWAP:
			alu_out = operand;
		// Loads and stores never reach the ALU state.
		// Leaving memory unchanged is the safe answer anyway
		default:
			alu_out = old_word;
		endcase
	end

	// The read word is complete by the time ALU is entered, so one
	// register stage here is enough
	always_ff @(posedge clk) begin
		if (state == ALU)
			result <= alu_out;
	end

endmodule

/* logic/mpmc_state_machine.sv */
module mpmc_state_machine import mpmc_bus_pkg::*, mpmc_ctrl_pkg::*; (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   calib_complete,
	// Hang timer has fired
	input  logic                   to,
	input  logic                   rdy,
	input  logic                   wdf_rdy,
	input  mpmc_req_t              req,
	input  logic [STRIP_CNT_W-1:0] req_strip_cnt,
	input  logic [STRIP_CNT_W-1:0] resp_strip_cnt,
	input  logic                   rd_data_valid,
	output mpmc_state_t            state,
	output strip_cmd_t             strip_cmd
);

	mpmc_state_t next_state;

	always_ff @(posedge clk) begin
		if (rst)
			state <= IDLE;
		else
			state <= next_state;
	end

	// =====================================================================
	// Next state
	// =====================================================================
	always_comb begin
		next_state = state;
		case (state)
		// Nothing starts until the memory has calibrated
		IDLE:
			if (req.valid && calib_complete)
				next_state = PRESET1;
		PRESET1:
			next_state = PRESET2;
		PRESET2:
			if (req.cmd == CMD_STORE)
				next_state = WRITE_DATA0;
			else
				next_state = READ_DATA0;

		// Write command goes out when the memory takes commands
		WRITE_DATA0:
			if (rdy)
				next_state = WRITE_DATA1;
		WRITE_DATA1:
			next_state = WRITE_DATA2;
		WRITE_DATA2:
			if (rdy)
				next_state = WRITE_DATA3;
		// Write data is taken once wdf_rdy is up
		WRITE_DATA3:
			if (wdf_rdy)
				next_state = ACK;

		READ_DATA0:
			next_state = READ_DATA1;
		// Keep issuing strips until the last one has been accepted
		READ_DATA1:
			if (rdy && req_strip_cnt == STRIP_LAST)
				next_state = READ_DATA2;
		// The earlier strip was already counted when the last one shows up
		READ_DATA2:
			if (rd_data_valid && resp_strip_cnt == STRIP_LAST) begin
				if (req.cmd == CMD_LOAD)
					next_state = ACK;
				else
					next_state = ALU;
			end

		// Result is registered in ALU and moved into the request in ALU1
		ALU:
			next_state = ALU1;
		ALU1:
			next_state = WRITE_TRAMP1;
		WRITE_TRAMP1:
			next_state = WRITE_DATA0;

		// One cycle of ack, then back for the next request
		ACK:
			next_state = IDLE;
		default:
			next_state = IDLE;
		endcase

		// A hung sequence is abandoned, but never while still calibrating
		if (to && calib_complete)
			next_state = IDLE;
	end

	// =====================================================================
	// Strip command
	// =====================================================================
	always_comb begin
		strip_cmd.en    = 1'b0;
		strip_cmd.we    = 1'b0;
		strip_cmd.adr   = {req.adr, {STRIP_SEL_W{1'b0}}};
		// Store data, or the ALU result once it has been written back into req
		strip_cmd.wdata = req.dat;
		case (state)
		READ_DATA1: begin
			// The strip number is the count of strips accepted so far
			strip_cmd.en  = 1'b1;
			strip_cmd.adr = {req.adr, req_strip_cnt[STRIP_SEL_W-1:0]};
		end
		WRITE_DATA0, WRITE_DATA2: begin
			strip_cmd.en = 1'b1;
			strip_cmd.we = 1'b1;
		end
		// Data phase with no command
		WRITE_DATA3:
			strip_cmd.we = 1'b1;
		default: ;
		endcase
	end

endmodule

/* logic/mpmc_strip_counter.sv */
module mpmc_strip_counter import mpmc_bus_pkg::*, mpmc_ctrl_pkg::*; (
	input  logic                   clk,
	input  logic                   rst,
	input  mpmc_state_t            state,
	input  logic                   rdy,
	input  strip_rsp_t             rsp,
	output logic [STRIP_CNT_W-1:0] req_strip_cnt,
	output logic [STRIP_CNT_W-1:0] resp_strip_cnt,
	output logic [WB_DAT_W-1:0]    rd_word
);

	// =====================================================================
	// Request and response counts
	// =====================================================================

	// The command is always enabled in READ_DATA1.
	// So a strip is accepted in every cycle of it that has rdy
	always_ff @(posedge clk) begin
		if (rst)
			req_strip_cnt <= '0;
		else if (state == IDLE)
			req_strip_cnt <= '0;
		else if (state == READ_DATA1 && rdy)
			req_strip_cnt <= req_strip_cnt + 1'b1;
	end

	// Responses can already come back while requests are still going out,
	// so this count is not tied to a state
	always_ff @(posedge clk) begin
		if (rst)
			resp_strip_cnt <= '0;
		else if (state == IDLE)
			resp_strip_cnt <= '0;
		else if (rsp.rd_data_valid)
			resp_strip_cnt <= resp_strip_cnt + 1'b1;
	end

	// =====================================================================
	// Word assembly
	// =====================================================================

	// Strips return in order, low strip first.
	// Each one goes in at the top and pushes the previous one down, so after
	// the last strip the low strip is at the bottom
	always_ff @(posedge clk) begin
		if (rsp.rd_data_valid)
			rd_word <= {rsp.data, rd_word[WB_DAT_W-1:STRIP_W]};
	end

endmodule

/* logic/mpmc_strip_mem.sv */
module mpmc_strip_mem import mpmc_ctrl_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  strip_cmd_t strip_cmd,
	output logic       rdy,
	output logic       wdf_rdy,
	output logic       calib_complete,
	output strip_rsp_t rsp
);

	logic [STRIP_W-1:0]       mem [MEM_DEPTH];
	logic [CALIB_CNT_W-1:0]   calib_cnt;
	logic [REFRESH_CNT_W-1:0] refresh_cnt;
	logic                     refresh;
	// Word address latched from the last accepted write command
	logic [STRIP_ADR_W-STRIP_SEL_W-1:0] wr_adr;
	logic                     rd_accept;
	logic                     wr_accept;
	logic                     wr_commit;
	logic [READ_LATENCY-1:0]  vld_pipe;
	logic [STRIP_W-1:0]       dat_pipe [READ_LATENCY];

	// =====================================================================
	// Calibration and refresh
	// =====================================================================
	always_ff @(posedge clk) begin
		if (rst) begin
			calib_cnt      <= '0;
			calib_complete <= 1'b0;
			refresh_cnt    <= '0;
		end else begin
			refresh_cnt <= refresh_cnt + 1'b1;
			if (!calib_complete) begin
				calib_cnt <= calib_cnt + 1'b1;
				if (calib_cnt == CALIB_CYCLES - 1)
					calib_complete <= 1'b1;
			end
		end
	end

	// Last cycle of each refresh period is spent refreshing
	assign refresh = (refresh_cnt == REFRESH_PERIOD - 1);
	assign rdy     = calib_complete && !refresh;
	assign wdf_rdy = calib_complete && !refresh;

	// =====================================================================
	// Array and read pipeline
	// =====================================================================
	assign rd_accept = strip_cmd.en && !strip_cmd.we && rdy;
	assign wr_accept = strip_cmd.en && strip_cmd.we && rdy;
	assign wr_commit = !strip_cmd.en && strip_cmd.we && wdf_rdy;

	always_ff @(posedge clk) begin
		if (wr_accept)
			wr_adr <= strip_cmd.adr[STRIP_ADR_W-1:STRIP_SEL_W];
	end

	// Calibration wipes one slice of the array per cycle
	always_ff @(posedge clk) begin
		if (!calib_complete) begin
			for (int i = 0; i < CLEAR_STRIDE; i++)
				mem[calib_cnt * CLEAR_STRIDE + i] <= '0;
		end else if (wr_commit) begin
			mem[{wr_adr, 1'b0}] <= strip_cmd.wdata[STRIP_W-1:0];
			mem[{wr_adr, 1'b1}] <= strip_cmd.wdata[2*STRIP_W-1:STRIP_W];
		end
		// Array read in the first stage, the rest only delays the strip
		dat_pipe[0] <= mem[strip_cmd.adr];
		for (int i = 1; i < READ_LATENCY; i++)
			dat_pipe[i] <= dat_pipe[i-1];
	end

	// Several strips may be in flight, one per stage
	always_ff @(posedge clk) begin
		if (rst)
			vld_pipe <= '0;
		else
			vld_pipe <= {vld_pipe[READ_LATENCY-2:0], rd_accept};
	end

	assign rsp.rd_data_valid = vld_pipe[READ_LATENCY-1];
	assign rsp.data          = dat_pipe[READ_LATENCY-1];

endmodule

/* logic/mpmc_timeout.sv */
module mpmc_timeout import mpmc_ctrl_pkg::*; (
	input  logic        clk,
	input  logic        rst,
	input  mpmc_state_t state,
	output logic        to
);

	logic [TIMEOUT_CNT_W-1:0] cnt;

	// Every cycle outside IDLE counts against the limit.
	// The count sticks at the limit until the state machine drops back
	always_ff @(posedge clk) begin
		if (rst)
			cnt <= '0;
		else if (state == IDLE)
			cnt <= '0;
		else if (cnt != TIMEOUT_LIMIT[TIMEOUT_CNT_W-1:0])
			cnt <= cnt + 1'b1;
	end

	// Held high only in the last cycle before the forced return to IDLE
	assign to = (cnt == TIMEOUT_LIMIT[TIMEOUT_CNT_W-1:0]);

endmodule

/* logic/mpmc_top.sv */
module mpmc_top import mpmc_bus_pkg::*, mpmc_ctrl_pkg::*; (
	input  logic                clk,
	input  logic                rst,
	// Wishbone classic slave
	input  logic                cyc,
	input  logic                stb,
	input  logic                we,
	input  logic [WB_ADR_W-1:0] adr,
	input  logic [WB_DAT_W-1:0] dat_w,
	input  mpmc_cmd_t           cmd,
	output logic                ack,
	output logic                err,
	output logic [WB_DAT_W-1:0] dat_r
);

	mpmc_req_t                req;
	mpmc_state_t              state;
	strip_cmd_t               strip_cmd;
	strip_rsp_t               rsp;
	logic                     calib_complete;
	logic                     to;
	logic                     rdy;
	logic                     wdf_rdy;
	logic [STRIP_CNT_W-1:0]   req_strip_cnt;
	logic [STRIP_CNT_W-1:0]   resp_strip_cnt;
	logic [WB_DAT_W-1:0]      rd_word;
	logic [WB_DAT_W-1:0]      alu_result;
	logic                     capture;

	// =====================================================================
	// Command register
	// =====================================================================
	assign capture = (state == IDLE) && cyc && stb && !req.valid;

	always_ff @(posedge clk) begin
		if (capture) begin
			// A write cycle carrying the load opcode is taken as a store
			req.cmd <= (we && cmd == CMD_LOAD) ? CMD_STORE : cmd;
			req.adr <= adr;
			req.dat <= dat_w;
		end else if (state == ALU1) begin
			// The write-back sequence sends whatever is in req.dat
			req.dat <= alu_result;
		end
		if (rst)
			req.valid <= 1'b0;
		else if (capture)
			req.valid <= 1'b1;
		else if (state == ACK || err)
			req.valid <= 1'b0;
	end

	// Bus responses come straight from the sequencing state
	assign ack   = (state == ACK);
	assign err   = to && (state != IDLE);
	// The read word is untouched by the write-back, so atomics return the old value
	assign dat_r = (req.cmd == CMD_STORE) ? req.dat : rd_word;

	// =====================================================================
	// Instances
	// =====================================================================
	mpmc_state_machine i_state_machine (
		.clk            (clk),
		.rst            (rst),
		.calib_complete (calib_complete),
		.to             (to),
		.rdy            (rdy),
		.wdf_rdy        (wdf_rdy),
		.req            (req),
		.req_strip_cnt  (req_strip_cnt),
		.resp_strip_cnt (resp_strip_cnt),
		.rd_data_valid  (rsp.rd_data_valid),
		.state          (state),
		.strip_cmd      (strip_cmd)
	);

	mpmc_timeout i_timeout (
		.clk   (clk),
		.rst   (rst),
		.state (state),
		.to    (to)
	);

	mpmc_strip_counter i_strip_counter (
		.clk            (clk),
		.rst            (rst),
		.state          (state),
		.rdy            (rdy),
		.rsp            (rsp),
		.req_strip_cnt  (req_strip_cnt),
		.resp_strip_cnt (resp_strip_cnt),
		.rd_word        (rd_word)
	);

	mpmc_rmw_alu i_rmw_alu (
		.clk      (clk),
		.state    (state),
		.cmd      (req.cmd),
		.old_word (rd_word),
		.operand  (req.dat),
		.result   (alu_result)
	);

	mpmc_strip_mem i_strip_mem (
		.clk            (clk),
		.rst            (rst),
		.strip_cmd      (strip_cmd),
		.rdy            (rdy),
		.wdf_rdy        (wdf_rdy),
		.calib_complete (calib_complete),
		.rsp            (rsp)
	);

endmodule

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal -f src.f --top-module mpmc_tb -o mpmc_sim &&
./obj_dir/mpmc_sim | tee /dev/stderr | grep -q "Simulation completed successfully" &&
echo "PASS" ||
{ echo "FAIL"; exit 1; }

/* src.f */
logic/mpmc_bus_pkg.sv
logic/mpmc_ctrl_pkg.sv
logic/mpmc_state_machine.sv
logic/mpmc_timeout.sv
logic/mpmc_strip_counter.sv
logic/mpmc_rmw_alu.sv
logic/mpmc_strip_mem.sv
logic/mpmc_top.sv
+incdir+tb
tb/mpmc_tb.sv

/* tb/mpmc_model.svh */
`ifndef MPMC_MODEL_SVH
`define MPMC_MODEL_SVH

// Word image of the whole address space, as the master should see it
logic [31:0] model_mem [256];

// Calibration leaves every strip at zero
function automatic void clear_model();
	for (int i = 0; i < 256; i++)
		model_mem[i] = '0;
endfunction

// New memory word after an atomic op on old_word with the master's operand
function automatic logic [31:0] alu_rule(mpmc_cmd_t op, logic [31:0] old_word,
		logic [31:0] operand);
	int signed old_s;
	int signed opd_s;
	old_s = old_word;
	opd_s = operand;
	case (op)
	CMD_ADD:  return old_word + operand;
	CMD_OR:   return old_word | operand;
	CMD_AND:  return old_word & operand;
	CMD_EOR:  return old_word ^ operand;
	// Signed variants treat bit 31 as the sign
	CMD_MIN:  return (opd_s < old_s) ? operand : old_word;
	CMD_MAX:  return (opd_s > old_s) ? operand : old_word;
	CMD_MINU: return (operand < old_word) ? operand : old_word;
	CMD_MAXU: return (operand > old_word) ? operand : old_word;
	CMD_SWAP: return operand;
	default:  return old_word;
	endcase
endfunction

// Word that dat_r must carry at ack, with the model updated as a side effect
task automatic predict_response(input mpmc_cmd_t op, input logic [7:0] a,
		input logic [31:0] d, output logic [31:0] expected);
	expected = model_mem[a];
	case (op)
	CMD_LOAD: ;
	CMD_STORE: begin
		model_mem[a] = d;
		expected     = d;
	end
	// Atomics hand back the old word and leave the new one behind
	default:
		model_mem[a] = alu_rule(op, expected, d);
	endcase
endtask

`endif

/* tb/mpmc_tb.sv */
module mpmc_tb import mpmc_bus_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	`include "mpmc_model.svh"

	localparam int CLK_PERIOD    = 20;
	localparam int DRIVE_DELAY   = 2;
	localparam int NUM_OPS       = 400;
	// Small address window so that words get hit again and again
	localparam int WINDOW_WORDS  = 16;
	localparam logic [WB_ADR_W-1:0] WINDOW_BASE = 8'h70;
	// Generous per-op budget that an atomic op stays well under
	localparam int CYCLES_PER_OP = 60;
	localparam int MAX_CYCLES    = (NUM_OPS + WINDOW_WORDS) * CYCLES_PER_OP;

	logic                clk;
	logic                rst;
	logic                cyc;
	logic                stb;
	logic                we;
	logic [WB_ADR_W-1:0] adr;
	logic [WB_DAT_W-1:0] dat_w;
	mpmc_cmd_t           cmd;
	logic                ack;
	logic                err;
	logic [WB_DAT_W-1:0] dat_r;

	integer seed;
	int     cycles;

	mpmc_top i_dut (
		.clk   (clk),
		.rst   (rst),
		.cyc   (cyc),
		.stb   (stb),
		.we    (we),
		.adr   (adr),
		.dat_w (dat_w),
		.cmd   (cmd),
		.ack   (ack),
		.err   (err),
		.dat_r (dat_r)
	);

	// =====================================================================
	// Clock and watchdog
	// =====================================================================
	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// A stuck handshake anywhere ends up here
	initial begin
		cycles = 0;
		forever begin
			@(posedge clk);
			cycles++;
			if (cycles >= MAX_CYCLES) begin
				$display("Run timed out after %0d cycles without finishing", cycles);
				$display("Simulation failed");
				$fatal(1);
			end
		end
	end

	// =====================================================================
	// Checks and bus tasks
	// =====================================================================
	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			$display("Error at time %0t: %s expected %h, actual %h",
				$time, name, expected, actual);
			$display("Simulation failed");
			$fatal(1);
		end
	endtask

	// One classic cycle, entered and left DRIVE_DELAY after a rising edge
	task automatic run_op(input mpmc_cmd_t op, input logic [WB_ADR_W-1:0] a,
			input logic [WB_DAT_W-1:0] d);
		logic [WB_DAT_W-1:0] expected;
		predict_response(op, a, d, expected);
		cyc   = 1'b1;
		stb   = 1'b1;
		we    = (op != CMD_LOAD);
		adr   = a;
		dat_w = d;
		cmd   = op;
		// Outputs are read mid-cycle where they are settled
		do begin
			@(negedge clk);
			check_value("err", 32'd0, {31'd0, err});
		end while (!ack);
		check_value("dat_r", expected, dat_r);
		@(posedge clk);
		#DRIVE_DELAY;
		cyc = 1'b0;
		stb = 1'b0;
		we  = 1'b0;
		// The idle cycle must not carry a second ack
		@(negedge clk);
		check_value("ack", 32'd0, {31'd0, ack});
		check_value("err", 32'd0, {31'd0, err});
		@(posedge clk);
		#DRIVE_DELAY;
	endtask

	// Mix is roughly a quarter loads, a fifth stores and the rest atomics
	task automatic issue_random();
		int                  pick;
		logic [WB_ADR_W-1:0] a;
		logic [WB_DAT_W-1:0] d;
		mpmc_cmd_t           op;
		pick = $unsigned($random(seed)) % 16;
		a    = WINDOW_BASE + WB_ADR_W'($unsigned($random(seed)) % WINDOW_WORDS);
		d    = $random(seed);
		if (pick < 4)
			op = CMD_LOAD;
		else if (pick < 7)
			op = CMD_STORE;
		else
			op = mpmc_cmd_t'(pick - 5);   // 7..15 covers ADD up to SWAP
		run_op(op, a, d);
	endtask

	// =====================================================================
	// Test sequence
	// =====================================================================
	initial begin
		rst   = 1'b1;
		cyc   = 1'b0;
		stb   = 1'b0;
		we    = 1'b0;
		adr   = '0;
		dat_w = '0;
		cmd   = CMD_LOAD;
		seed  = 32'h73d1c7fc;
		clear_model();
		repeat (4) @(posedge clk);
		#DRIVE_DELAY;
		rst = 1'b0;

		// The first requests arrive while the memory is still calibrating,
		// and refresh stalls fall at random points of every sequence
		for (int i = 0; i < NUM_OPS; i++)
			issue_random();

		// Every word of the window must now read back as the model has it
		for (int i = 0; i < WINDOW_WORDS; i++)
			run_op(CMD_LOAD, WINDOW_BASE + WB_ADR_W'(i), '0);

		$display("Simulation completed successfully");
		$finish;
	end

endmodule
